//--- source/beam_pkg.sv
// shared definitions for the four-channel complex beamformer
// widths, counts, pipeline latencies and the packed beat types live here
// RTL modules import this package inside their bodies and use scoped
// names for their port types
package beam_pkg;

    // bits in one real or imaginary sample part
    localparam int SAMPLE_WIDTH = 16;

    // bits in one real or imaginary weight part
    localparam int WEIGHT_WIDTH = 8;

    // weights are fractions of 256, so every product is shifted right by this much
    localparam int WEIGHT_FRAC_BITS = 8;

    // complex samples carried in one beat
    localparam int LANES = 8;

    // antenna channels summed into the beam
    localparam int CHANNELS = 4;

    // input beat to weighted beat, one cycle per weighter stage
    localparam int WEIGHTER_LATENCY = 3;

    // input beat to beam output, the combiner adds one register
    localparam int BEAM_LATENCY = 4;

    // one signed sample part
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // one signed weight part
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;

    // selects the channel whose weight is written
    typedef logic [$clog2(CHANNELS)-1:0] channel_sel_t;

    // real part sits in the upper half of the 32-bit word
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    // lane 0 occupies the low 32 bits of the beat
    typedef cplx_sample_t [LANES-1:0] lane_data_t;

    // used for channel inputs, weighted beats and the beam output alike
    typedef struct packed {
        logic       valid;
        logic       last;
        lane_data_t data;
    } channel_beat_t;

    // write port of the weight bank, sampled on the rising edge when we is high
    typedef struct packed {
        logic         we;
        channel_sel_t sel;
        cplx_weight_t weight;
    } weight_write_t;

endpackage

//--- source/weight_bank.sv
// complex weight registers for the beamformer, one per channel
// a write strobe stores one weight for the selected channel
// the stored weights feed the weighters continuously
`timescale 1ns/1ps

module weight_bank (
    input  logic                                          clock,
    input  logic                                          resetn,
    input  beam_pkg::weight_write_t                       weight_wr,
    output beam_pkg::cplx_weight_t [beam_pkg::CHANNELS-1:0] weights
);
    import beam_pkg::*;

    // the bank is written one channel at a time
    // a write at one edge is seen by the weighters from the next edge on
    always_ff @(posedge clock) begin
        if (!resetn) begin
            // all channels start with a zero weight, so the beam is silent
            // until software programs the bank
            weights <= '0;
        end else begin
            if (weight_wr.we) begin
                // only the addressed register changes
                // the other channels keep steering with their old weight
                weights[weight_wr.sel] <= weight_wr.weight;
            end
        end
    end

endmodule

//--- source/complex_weighter.sv
// applies one channel's complex weight to each of the eight lanes of a beat
// three register stages: capture, scaled products, complex combine
// the weighted beat appears WEIGHTER_LATENCY cycles after the input beat
// data of an invalid weighted beat is forced to zero
`timescale 1ns/1ps

module complex_weighter (
    input  logic                    clock,
    input  logic                    resetn,
    input  beam_pkg::channel_beat_t ch_in,
    input  beam_pkg::cplx_weight_t  weight,
    output beam_pkg::channel_beat_t weighted
);
    import beam_pkg::*;

    // stage 1 holds the captured beat and the weight that goes with it
    logic         s1_valid;
    logic         s1_last;
    lane_data_t   s1_data;
    cplx_weight_t s1_weight;

    // stage 2 holds the four scaled partial products of every lane
    logic                    s2_valid;
    logic                    s2_last;
    sample_t [LANES-1:0]     s2_rr;
    sample_t [LANES-1:0]     s2_ii;
    sample_t [LANES-1:0]     s2_ri;
    sample_t [LANES-1:0]     s2_ir;

    // signed sample times signed weight, floor shifted and wrapped to 16 bits
    // the full product fits in 24 bits even for -32768 times -128
    function automatic sample_t scale(input sample_t s, input weight_t w);
        logic signed [SAMPLE_WIDTH+WEIGHT_WIDTH-1:0] product;
        product = s * w;
        // arithmetic shift gives floor, the cast keeps the low 16 bits
        return sample_t'(product >>> WEIGHT_FRAC_BITS);
    endfunction

    // stage 1 control
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= ch_in.valid;
            // last only means something together with valid
            s1_last  <= ch_in.valid & ch_in.last;
        end
    end

    // stage 1 payload, loaded only for real beats
    // the weight is captured with the beat so a later rewrite of the bank
    // cannot touch a beat already in flight
    always_ff @(posedge clock) begin
        if (ch_in.valid) begin
            s1_data   <= ch_in.data;
            s1_weight <= weight;
        end
    end

    // stage 2 control
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
        end
    end

    // stage 2 products, each lane uses the same weight
    always_ff @(posedge clock) begin
        if (s1_valid) begin
            for (int lane = 0; lane < LANES; lane++) begin
                s2_rr[lane] <= scale(s1_data[lane].re, s1_weight.re);
                s2_ii[lane] <= scale(s1_data[lane].im, s1_weight.im);
                // cross terms feed the imaginary result
                s2_ri[lane] <= scale(s1_data[lane].re, s1_weight.im);
                s2_ir[lane] <= scale(s1_data[lane].im, s1_weight.re);
            end
        end
    end

    // stage 3 forms (a + jb)(c + jd) = (ac - bd) + j(ad + bc) per lane
    // both sums wrap to 16 bits on assignment
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weighted <= '0;
        end else begin
            weighted.valid <= s2_valid;
            weighted.last  <= s2_last;
            for (int lane = 0; lane < LANES; lane++) begin
                if (s2_valid) begin
                    weighted.data[lane].re <= s2_rr[lane] - s2_ii[lane];
                    weighted.data[lane].im <= s2_ri[lane] + s2_ir[lane];
                end else begin
                    // stale products from an old beat must not leak out
                    weighted.data[lane] <= '0;
                end
            end
        end
    end

endmodule

//--- source/beam_combiner.sv
// sums the four weighted channel beats lane by lane into one beam beat
// a beam beat is formed only when all four channels are valid together
// the output is registered, with zero data whenever it is not valid
`timescale 1ns/1ps

module beam_combiner (
    input  logic                                            clock,
    input  logic                                            resetn,
    input  beam_pkg::channel_beat_t [beam_pkg::CHANNELS-1:0] weighted,
    output beam_pkg::channel_beat_t                          beam_out
);
    import beam_pkg::*;

    // high when every channel delivers a weighted beat this cycle
    logic       all_valid;

    // lane-wise sum of all channels, wrapped to the sample width
    lane_data_t sum_data;

    always_comb begin
        all_valid = 1'b1;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            all_valid = all_valid & weighted[ch].valid;
        end
    end

    // accumulating in 16-bit parts gives the same wrap as a wide sum
    // truncated at the end
    always_comb begin
        sum_data = '0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            for (int lane = 0; lane < LANES; lane++) begin
                sum_data[lane].re = sum_data[lane].re + weighted[ch].data[lane].re;
                sum_data[lane].im = sum_data[lane].im + weighted[ch].data[lane].im;
            end
        end
    end

    // the beam follows channel 0 for framing, the other last bits are ignored
    // there is no back-pressure, so the beat must be taken when valid
    always_ff @(posedge clock) begin
        if (!resetn) begin
            beam_out <= '0;
        end else begin
            if (all_valid) begin
                beam_out.valid <= 1'b1;
                beam_out.last  <= weighted[0].last;
                beam_out.data  <= sum_data;
            end else begin
                // a partial set of channels makes no beam beat
                beam_out <= '0;
            end
        end
    end

endmodule

//--- source/beamformer_top.sv
// top level of the four-channel complex beamformer
// the weight bank steers four identical weighters, one per channel,
// and the combiner sums their outputs into a single beam
// beam_out follows a fully valid input cycle by BEAM_LATENCY cycles
`timescale 1ns/1ps

module beamformer_top (
    input  logic                                            clock,
    input  logic                                            resetn,
    input  beam_pkg::weight_write_t                          weight_wr,
    input  beam_pkg::channel_beat_t [beam_pkg::CHANNELS-1:0] ch_in,
    output beam_pkg::channel_beat_t                          beam_out
);
    import beam_pkg::*;

    // current complex weight of every channel
    cplx_weight_t [CHANNELS-1:0]  weights;

    // weighted beats, all arriving in the same cycle for a common input beat
    channel_beat_t [CHANNELS-1:0] weighted;

    // configuration registers written through the strobe port
    weight_bank weight_bank_inst (
        .clock     (clock),
        .resetn    (resetn),
        .weight_wr (weight_wr),
        .weights   (weights)
    );

    // one weighting pipeline per channel
    // the weighters share no state, so each channel may run on its own
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_weighter
        complex_weighter complex_weighter_inst (
            .clock    (clock),
            .resetn   (resetn),
            .ch_in    (ch_in[ch]),
            .weight   (weights[ch]),
            .weighted (weighted[ch])
        );
    end

    // the combiner only forms a beam when all channels line up
    beam_combiner beam_combiner_inst (
        .clock    (clock),
        .resetn   (resetn),
        .weighted (weighted),
        .beam_out (beam_out)
    );

endmodule

//--- tests/beam_model.svh
// reference model for the beamformer testbench
// computes expected beam beats straight from the fixed-point rules and
// supplies pseudo-random bits from a 32-bit Fibonacci LFSR
// included inside the testbench module, after the package import
`ifndef BEAM_MODEL_SVH
`define BEAM_MODEL_SVH

// one beat per channel, as presented to the top level in one cycle
typedef channel_beat_t [CHANNELS-1:0] channel_set_t;

// one complex weight per channel
typedef cplx_weight_t [CHANNELS-1:0] weight_set_t;

// LFSR state for the polynomial x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'h3e0bb3ea;

// one LFSR step yields one random bit
function automatic logic next_lfsr_bit();
    logic feedback;
    feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
endfunction

// collects count bits, the first bit taken ends up most significant
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        value = {value[30:0], next_lfsr_bit()};
    end
    return value;
endfunction

// keeps the low 16 bits of a wide result as a signed sample part
function automatic sample_t wrap_sample(input int value);
    logic [31:0] bits;
    bits = value;
    return bits[SAMPLE_WIDTH-1:0];
endfunction

// product divided by 256, rounded toward minus infinity
function automatic int floor_scale(input int sample, input int weight);
    int product;
    int divisor;
    product = sample * weight;
    divisor = 1 << WEIGHT_FRAC_BITS;
    if (product >= 0) begin
        return product / divisor;
    end
    // integer division truncates toward zero, so negative products round down by hand
    return -((-product + divisor - 1) / divisor);
endfunction

// (a + jb)(c + jd) with every product scaled and the parts wrapped
function automatic cplx_sample_t weight_sample(input cplx_sample_t x, input cplx_weight_t w);
    cplx_sample_t result;
    result.re = wrap_sample(floor_scale(x.re, w.re) - floor_scale(x.im, w.im));
    result.im = wrap_sample(floor_scale(x.re, w.im) + floor_scale(x.im, w.re));
    return result;
endfunction

// lane-wise sum over all channels of the weighted samples
function automatic lane_data_t expected_beam(input channel_set_t beats, input weight_set_t w);
    lane_data_t   result;
    cplx_sample_t part;
    int           re_sum;
    int           im_sum;
    for (int lane = 0; lane < LANES; lane++) begin
        re_sum = 0;
        im_sum = 0;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            part = weight_sample(beats[ch].data[lane], w[ch]);
            re_sum = re_sum + part.re;
            im_sum = im_sum + part.im;
        end
        result[lane].re = wrap_sample(re_sum);
        result[lane].im = wrap_sample(im_sum);
    end
    return result;
endfunction

`endif

//--- tests/beamformer_tb.sv
// testbench for the four-channel complex beamformer
// drives random and corner-case beats into beamformer_top and checks every
// output cycle against a queue of model beats tagged with their due cycle
// six tests run in sequence, each reports on its own, then a summary line
`timescale 1ns/1ps

module beamformer_tb;
    import beam_pkg::*;

    localparam int CLOCK_PERIOD  = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CYCLES   = 16;
    localparam int GAP_BEATS     = 24;
    localparam int RANDOM_BEATS  = 40;
    localparam int LAST_BEATS    = 16;
    localparam int STREAM_BEATS  = 32;
    localparam int DRAIN_CYCLES  = BEAM_LATENCY + 2;
    // upper bounds of all six tests, weight writes and drains included
    localparam int TEST_CYCLES   = RESET_CYCLES + IDLE_CYCLES + 4 * GAP_BEATS + RANDOM_BEATS
                                 + LAST_BEATS + STREAM_BEATS + 60
                                 + 6 * (CHANNELS + DRAIN_CYCLES);
    localparam int MARGIN_CYCLES = 100;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + MARGIN_CYCLES;

    `include "beam_model.svh"

    // a beam beat the DUT owes, with the cycle in which it must appear
    typedef struct packed {
        int         due;
        logic       last;
        lane_data_t data;
    } expected_beat_t;

    logic          clock;
    logic          resetn;
    weight_write_t weight_wr;
    channel_set_t  ch_in;
    channel_beat_t beam_out;

    int cycle = 0;
    int error_count = 0;
    int errors_at_start = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int beats_checked = 0;
    // valid beam beats seen on the DUT output
    int valid_outputs = 0;

    expected_beat_t expected_q[$];
    // the weights the bank holds once all driven writes have landed
    weight_set_t    model_weights = '0;

    beamformer_top beamformer_top_inst (
        .clock     (clock),
        .resetn    (resetn),
        .weight_wr (weight_wr),
        .ch_in     (ch_in),
        .beam_out  (beam_out)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // cycle numbers tag the expected beats
    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic report_mismatch(input string name, input logic [255:0] expected,
                                   input logic [255:0] actual);
        $display("FAILED at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    // an output that is not valid carries no data
    property idle_data_zero;
        @(posedge clock) !beam_out.valid |-> beam_out.data == '0;
    endproperty

    idle_data_check: assert property (idle_data_zero)
        else report_mismatch("beam_out.data", '0, beam_out.data);

    function automatic logic every_channel_valid(input channel_set_t beats);
        for (int ch = 0; ch < CHANNELS; ch++) begin
            if (!beats[ch].valid) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_beam(input expected_beat_t expected);
        assert (beam_out.valid == 1'b1)
            else report_mismatch("beam_out.valid", 1, beam_out.valid);
        assert (beam_out.last == expected.last)
            else report_mismatch("beam_out.last", expected.last, beam_out.last);
        for (int lane = 0; lane < LANES; lane++) begin
            assert (beam_out.data[lane] == expected.data[lane])
                else report_mismatch($sformatf("beam_out.data[%0d]", lane),
                                     expected.data[lane], beam_out.data[lane]);
        end
        beats_checked++;
    endtask

    // outputs are sampled on the falling edge, half a cycle after they change
    always @(negedge clock) begin
        expected_beat_t expected;
        if (beam_out.valid) begin
            valid_outputs++;
        end
        if (expected_q.size() > 0 && expected_q[0].due == cycle) begin
            expected = expected_q.pop_front();
            check_beam(expected);
        end else begin
            assert (beam_out.valid == 1'b0)
                else report_mismatch("beam_out.valid", 0, beam_out.valid);
            assert (beam_out.last == 1'b0)
                else report_mismatch("beam_out.last", 0, beam_out.last);
        end
    end

    // drives one cycle of beats and an optional weight write
    task automatic drive_cycle(input channel_set_t beats, input weight_write_t write);
        expected_beat_t expected;
        @(posedge clock);
        ch_in     <= beats;
        weight_wr <= write;
        if (every_channel_valid(beats)) begin
            // the beat is captured one edge later, before this cycle's write lands,
            // so it still sees the old weights
            expected.due  = cycle + 1 + BEAM_LATENCY;
            expected.last = beats[0].last;
            expected.data = expected_beam(beats, model_weights);
            expected_q.push_back(expected);
        end
        if (write.we) begin
            model_weights[write.sel] = write.weight;
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) drive_cycle('0, '0);
    endtask

    task automatic send(input channel_set_t beats);
        drive_cycle(beats, '0);
    endtask

    task automatic write_weight(input int sel, input cplx_weight_t weight);
        weight_write_t write;
        write.we     = 1'b1;
        write.sel    = channel_sel_t'(sel);
        write.weight = weight;
        drive_cycle('0, write);
    endtask

    function automatic cplx_weight_t random_weight();
        cplx_weight_t weight;
        weight.re = weight_t'(random_bits(WEIGHT_WIDTH));
        weight.im = weight_t'(random_bits(WEIGHT_WIDTH));
        return weight;
    endfunction

    task automatic write_random_weights();
        for (int ch = 0; ch < CHANNELS; ch++) begin
            write_weight(ch, random_weight());
        end
    endtask

    function automatic channel_set_t random_beats(input logic [CHANNELS-1:0] valid_mask);
        channel_set_t beats;
        for (int ch = 0; ch < CHANNELS; ch++) begin
            beats[ch].valid = valid_mask[ch];
            beats[ch].last  = next_lfsr_bit();
            for (int lane = 0; lane < LANES; lane++) begin
                beats[ch].data[lane].re = sample_t'(random_bits(SAMPLE_WIDTH));
                beats[ch].data[lane].im = sample_t'(random_bits(SAMPLE_WIDTH));
            end
        end
        return beats;
    endfunction

    // extreme sample values that push the products and sums into wrap
    function automatic sample_t corner_sample(input int index);
        case (index % 4)
            0:       return sample_t'(-32768);
            1:       return sample_t'(32767);
            2:       return sample_t'(-1);
            default: return sample_t'(1);
        endcase
    endfunction

    task automatic drain();
        idle(DRAIN_CYCLES);
        if (expected_q.size() != 0) begin
            $display("%0d expected beam beats never appeared at the output", expected_q.size());
            error_count++;
            expected_q.delete();
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        channel_set_t         beats;
        logic [CHANNELS-1:0]  mask;
        cplx_weight_t         weight;
        int                   stream_start;

        resetn    = 1'b0;
        ch_in     = '0;
        weight_wr = '0;

        // outputs stay quiet through reset and with no input
        start_test();
        repeat (RESET_CYCLES) @(posedge clock);
        resetn <= 1'b1;
        idle(IDLE_CYCLES);
        finish_test("reset and idle");

        // latency, and no beam from a cycle with a channel missing
        start_test();
        write_random_weights();
        for (int i = 0; i < GAP_BEATS; i++) begin
            mask = '1;
            if (i % 3 == 1) begin
                mask[random_bits(2) % CHANNELS] = 1'b0;
            end
            send(random_beats(mask));
            if (i % 4 == 3) begin
                idle(1 + i % 3);
            end
        end
        drain();
        finish_test("latency and partial valid");

        // random data, then full-scale samples against extreme weights
        start_test();
        write_random_weights();
        for (int i = 0; i < RANDOM_BEATS; i++) begin
            send(random_beats('1));
        end
        for (int set = 0; set < 2; set++) begin
            weight.re = weight_t'(set == 0 ? -128 : 127);
            weight.im = weight_t'(-128);
            for (int ch = 0; ch < CHANNELS; ch++) begin
                write_weight(ch, weight);
            end
            for (int k = 0; k < 4; k++) begin
                beats = random_beats('1);
                for (int ch = 0; ch < CHANNELS; ch++) begin
                    for (int lane = 0; lane < LANES; lane++) begin
                        beats[ch].data[lane].re = corner_sample(lane + ch + k);
                        beats[ch].data[lane].im = corner_sample(lane + 2 * ch + k + 1);
                    end
                end
                send(beats);
            end
        end
        drain();
        finish_test("random and corner data");

        // framing follows channel 0 alone
        start_test();
        for (int i = 0; i < LAST_BEATS; i++) begin
            beats = random_beats('1);
            beats[0].last = i[0];
            for (int ch = 1; ch < CHANNELS; ch++) begin
                beats[ch].last = ~beats[0].last;
            end
            send(beats);
        end
        drain();
        finish_test("last from channel 0");

        // a rewrite reaches only later beats, beats in flight keep the old weight
        start_test();
        write_random_weights();
        send(random_beats('1));
        send(random_beats('1));
        write_weight(2, random_weight());
        send(random_beats('1));
        send(random_beats('1));
        beats = random_beats('1);
        drive_cycle(beats, {1'b1, channel_sel_t'(0), random_weight()});
        send(random_beats('1));
        send(random_beats('1));
        drain();
        finish_test("weight rewrite");

        // every cycle carries a beat, so all pipeline stages are full
        start_test();
        write_random_weights();
        stream_start = valid_outputs;
        for (int i = 0; i < STREAM_BEATS; i++) begin
            send(random_beats('1));
        end
        drain();
        if (valid_outputs - stream_start != STREAM_BEATS) begin
            $display("back to back stream gave %0d beam beats instead of %0d",
                     valid_outputs - stream_start, STREAM_BEATS);
            error_count++;
        end
        finish_test("back to back stream");

        $display("tests passed %0d, failed %0d, beam beats checked %0d, errors %0d",
                 tests_passed, tests_failed, beats_checked, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+tests
source/beam_pkg.sv
source/weight_bank.sv
source/complex_weighter.sv
source/beam_combiner.sv
source/beamformer_top.sv
tests/beamformer_tb.sv
